//--- Makefile
TOP  := axi_to_mem_tb
SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): $(SRCS) filelist.f
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/axi_to_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_to_mem_tb import axi_mem_pkg::*; ();

  // Cycles any single wait may take.
  localparam int unsigned Timeout = 2000;
  localparam int unsigned NumRows = 11;
  // Row kinds.
  localparam logic [1:0] KindWr   = 2'd0;
  localparam logic [1:0] KindRd   = 2'd1;
  localparam logic [1:0] KindBoth = 2'd2;
  localparam logic [63:0] StrbFull = 64'hFFFF_FFFF_FFFF_FFFF;

  // One transaction; strb_pat holds one strobe byte per beat, beat zero lowest.
  // Both rows also read len+1 beats from raddr with ID id+1.
  typedef struct packed {
    logic [1:0]  kind;
    id_t         id;
    addr_t       addr;
    len_t        len;
    logic [31:0] seed;
    logic [63:0] strb_pat;
    addr_t       raddr;
  } row_t;

  logic     clk;
  logic     rst;
  aw_chan_t aw;
  logic     aw_valid;
  logic     aw_ready;
  w_chan_t  w;
  logic     w_valid;
  logic     w_ready;
  b_chan_t  b;
  logic     b_valid;
  logic     b_ready;
  ar_chan_t ar;
  logic     ar_valid;
  logic     ar_ready;
  r_chan_t  r;
  logic     r_valid;
  logic     r_ready;
  logic     busy;
  logic     bp_en;

  row_t    rows [NumRows];
  // Expected memory contents, one 64-bit word per entry.
  data_t   ref_mem [`MEM_WORDS];
  b_chan_t exp_b [$];
  r_chan_t exp_r [$];

  axi_to_mem_top axi_to_mem_top_i (
    .clk_i      ( clk      ),
    .rst_i      ( rst      ),
    .aw_i       ( aw       ),
    .aw_valid_i ( aw_valid ),
    .aw_ready_o ( aw_ready ),
    .w_i        ( w        ),
    .w_valid_i  ( w_valid  ),
    .w_ready_o  ( w_ready  ),
    .b_o        ( b        ),
    .b_valid_o  ( b_valid  ),
    .b_ready_i  ( b_ready  ),
    .ar_i       ( ar       ),
    .ar_valid_i ( ar_valid ),
    .ar_ready_o ( ar_ready ),
    .r_o        ( r        ),
    .r_valid_o  ( r_valid  ),
    .r_ready_i  ( r_ready  ),
    .busy_o     ( busy     )
  );

  always #4 clk = ~clk;

  task automatic stop_fail();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    stop_fail();
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, act, exp);
      stop_fail();
    end
  endtask

  task automatic check_b(input b_chan_t act, input b_chan_t exp);
    if (act.id !== exp.id) begin
      $display("** Error at %0t ns: b_o.id = %h, expected %h", $time, act.id, exp.id);
      stop_fail();
    end
  endtask

  task automatic check_r(input r_chan_t act, input r_chan_t exp);
    if (act.id !== exp.id) begin
      $display("** Error at %0t ns: r_o.id = %h, expected %h", $time, act.id, exp.id);
      stop_fail();
    end
    if (act.data !== exp.data) begin
      $display("** Error at %0t ns: r_o.data = %h, expected %h", $time, act.data, exp.data);
      stop_fail();
    end
    if (act.last !== exp.last) begin
      $display("** Error at %0t ns: r_o.last = %b, expected %b", $time, act.last, exp.last);
      stop_fail();
    end
  endtask

  // Distinct data per row and beat.
  function automatic data_t beat_data(input logic [31:0] seed, input int unsigned beat);
    logic [31:0] mix;
    mix = seed ^ (32'h9E37_79B9 * beat);
    return {mix, seed + beat};
  endfunction

  // Memory word that a beat of a burst lands on.
  function automatic int unsigned word_of(input addr_t addr, input int unsigned beat);
    return ((int'(addr) >> 3) + beat) % `MEM_WORDS;
  endfunction

  task automatic drive_aw(input id_t id, input addr_t addr, input len_t len);
    int unsigned cnt;
    b_chan_t     eb;
    @(negedge clk);
    aw.id    = id;
    aw.addr  = addr;
    aw.len   = len;
    aw_valid = 1'b1;
    cnt      = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("AW handshake");
    end while (!aw_ready);
    // One B per burst, in AW order.
    eb.id = id;
    exp_b.push_back(eb);
    @(negedge clk);
    // A burst just taken keeps the unroller busy.
    check_flag("busy_o", busy, 1'b1);
    aw_valid = 1'b0;
  endtask

  task automatic drive_w(input addr_t addr, input len_t len, input logic [31:0] seed,
                         input logic [63:0] strb_pat);
    int unsigned cnt;
    int unsigned word;
    data_t       d;
    strb_t       s;
    for (int unsigned i = 0; i <= int'(len); i++) begin
      d = beat_data(seed, i);
      s = strb_pat[i*8 +: 8];
      @(negedge clk);
      w.data  = d;
      w.strb  = s;
      w.last  = (i == int'(len));
      w_valid = 1'b1;
      cnt     = 0;
      do begin
        @(posedge clk);
        cnt++;
        if (cnt > Timeout) timeout_fail("W handshake");
      end while (!w_ready);
      // Only strobed bytes change.
      word = word_of(addr, i);
      for (int k = 0; k < 8; k++) begin
        if (s[k]) ref_mem[word][k*8 +: 8] = d[k*8 +: 8];
      end
    end
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  task automatic drive_ar(input id_t id, input addr_t addr, input len_t len);
    int unsigned cnt;
    r_chan_t     er;
    @(negedge clk);
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = len;
    ar_valid = 1'b1;
    cnt      = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("AR handshake");
    end while (!ar_ready);
    // Expected beats come from the model at acceptance.
    for (int unsigned i = 0; i <= int'(len); i++) begin
      er.id   = id;
      er.data = ref_mem[word_of(addr, i)];
      er.last = (i == int'(len));
      exp_r.push_back(er);
    end
    @(negedge clk);
    // The first read beat is still on its way to the FIFO.
    check_flag("busy_o", busy, 1'b1);
    ar_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("outstanding B and R responses");
    end while ((exp_b.size() != 0) || (exp_r.size() != 0));
  endtask

  task automatic load_table();
    rows[0]  = '{KindWr,   4'h1, 16'h0000, 8'd3, 32'h1000_0001, StrbFull, 16'h0000};
    rows[1]  = '{KindRd,   4'h2, 16'h0000, 8'd3, 32'h0, 64'h0, 16'h0000};
    rows[2]  = '{KindWr,   4'h3, 16'h0100, 8'd0, 32'h2000_0002, StrbFull, 16'h0000};
    rows[3]  = '{KindWr,   4'h4, 16'h0200, 8'd7, 32'h3000_0003, StrbFull, 16'h0000};
    // Partial strobes, second beat all zero.
    rows[4]  = '{KindWr,   4'h5, 16'h0200, 8'd3, 32'h4000_0004,
                 64'h0000_0000_F0A5_000F, 16'h0000};
    rows[5]  = '{KindRd,   4'h6, 16'h0200, 8'd7, 32'h0, 64'h0, 16'h0000};
    rows[6]  = '{KindRd,   4'h7, 16'h0100, 8'd0, 32'h0, 64'h0, 16'h0000};
    // Write and read together on disjoint regions.
    rows[7]  = '{KindBoth, 4'h8, 16'h0400, 8'd7, 32'h5000_0005, StrbFull, 16'h0200};
    rows[8]  = '{KindBoth, 4'hA, 16'h0000, 8'd3, 32'h6000_0006,
                 64'h0000_0000_81FF_003C, 16'h0400};
    rows[9]  = '{KindRd,   4'hC, 16'h0000, 8'd3, 32'h0, 64'h0, 16'h0000};
    rows[10] = '{KindRd,   4'hD, 16'h0400, 8'd7, 32'h0, 64'h0, 16'h0000};
  endtask

  // Random back-pressure on both response channels.
  always @(negedge clk) begin
    if (bp_en) begin
      b_ready = ($urandom % 4) != 0;
      r_ready = ($urandom % 3) != 0;
    end
  end

  // Response monitor, checked in arrival order per channel.
  always @(posedge clk) begin
    if (!rst) begin
      if (b_valid && b_ready) begin
        if (exp_b.size() == 0) begin
          $display("Unexpected B response with ID %h at %0t ns", b.id, $time);
          stop_fail();
        end else begin
          check_b(b, exp_b.pop_front());
        end
      end
      if (r_valid && r_ready) begin
        if (exp_r.size() == 0) begin
          $display("Unexpected R beat with ID %h at %0t ns", r.id, $time);
          stop_fail();
        end else begin
          check_r(r, exp_r.pop_front());
        end
      end
    end
  end

  initial begin
    int unsigned cnt;
    row_t        row;
    void'($urandom(66335));
    bp_en    = 1'b0;
    clk      = 1'b0;
    rst      = 1'b1;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    load_table();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("b_valid_o", b_valid, 1'b0);
    check_flag("r_valid_o", r_valid, 1'b0);
    check_flag("busy_o", busy, 1'b0);
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("aw_ready_o after reset");
    end while (!aw_ready);
    bp_en = 1'b1;
    for (int k = 0; k < NumRows; k++) begin
      row = rows[k];
      case (row.kind)
        KindWr: begin
          fork
            drive_aw(row.id, row.addr, row.len);
            drive_w(row.addr, row.len, row.seed, row.strb_pat);
          join
        end
        KindRd: begin
          drive_ar(row.id, row.addr, row.len);
        end
        default: begin
          fork
            drive_aw(row.id, row.addr, row.len);
            drive_w(row.addr, row.len, row.seed, row.strb_pat);
            drive_ar(id_t'(row.id + 4'd1), row.raddr, row.len);
          join
        end
      endcase
      wait_drained();
    end
    // Unroller must go idle once every burst is answered.
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > Timeout) timeout_fail("busy_o to fall");
    end while (busy);
    repeat (4) @(negedge clk);
    check_flag("b_valid_o", b_valid, 1'b0);
    check_flag("r_valid_o", r_valid, 1'b0);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+rtl
rtl/axi_mem_pkg.sv
rtl/sram_bank.sv
rtl/stream_fifo.sv
rtl/axi_burst_unroll.sv
rtl/mem_resp_gen.sv
rtl/axi_to_mem_top.sv
dv/axi_to_mem_tb.sv

//--- rtl/axi_burst_unroll.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_unroll import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Write address.
  input  aw_chan_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  // Write data.
  input  w_chan_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  // Read address.
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  // Single-beat requests to the request FIFO.
  output mem_req_t req_o,
  output logic     req_valid_o,
  input  logic     req_ready_i,
  output logic     busy_o
);

  // Address bits below the word index.
  localparam int unsigned WordOff = $clog2($bits(strb_t));

  // Control state.
  logic       en_q;
  logic       active_q;
  logic       prio_wr_q;
  logic       req_valid_q;
  // Active burst.
  logic       is_wr_q;
  id_t        id_q;
  word_addr_t addr_q;
  len_t       cnt_q;
  mem_req_t   req_q;

  logic       can_load;
  logic       aw_fire;
  logic       ar_fire;
  logic       wr_fire;
  logic       rd_fire;
  logic       beat_fire;
  logic       beat_last;
  word_addr_t ar_word;
  word_addr_t beat_addr;
  len_t       beat_cnt;
  id_t        beat_id;

  // The output register takes a beat when empty or draining.
  assign can_load = !req_valid_q || req_ready_i;

  // New bursts only at a burst boundary.
  // On contention the direction served last waits.
  assign aw_ready_o = en_q && !active_q && (prio_wr_q || !ar_valid_i);
  assign ar_ready_o = en_q && !active_q && can_load && (!prio_wr_q || !aw_valid_i);
  assign aw_fire    = aw_valid_i && aw_ready_o;
  assign ar_fire    = ar_valid_i && ar_ready_o;

  // One W beat per memory request.
  assign w_ready_o = active_q && is_wr_q && can_load;
  assign wr_fire   = w_valid_i && w_ready_o;
  // Later read beats need no handshake from the master.
  assign rd_fire   = active_q && !is_wr_q && can_load;

  // The first read beat leaves straight from AR.
  assign ar_word   = ar_i.addr[WordOff +: $bits(word_addr_t)];
  assign beat_addr = ar_fire ? ar_word : addr_q;
  assign beat_cnt  = ar_fire ? ar_i.len : cnt_q;
  assign beat_id   = ar_fire ? ar_i.id : id_q;
  assign beat_fire = wr_fire || rd_fire || ar_fire;
  assign beat_last = (beat_cnt == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q        <= 1'b0;
      active_q    <= 1'b0;
      prio_wr_q   <= 1'b1;
      req_valid_q <= 1'b0;
    end else begin
      // Ports open one cycle after reset.
      en_q <= 1'b1;
      if (aw_fire) begin
        active_q  <= 1'b1;
        prio_wr_q <= 1'b0;
      end else if (beat_fire) begin
        active_q <= !beat_last;
      end
      if (ar_fire) begin
        prio_wr_q <= 1'b1;
      end
      if (beat_fire) begin
        req_valid_q <= 1'b1;
      end else if (req_ready_i) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  // Burst bookkeeping.
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      is_wr_q <= 1'b1;
      id_q    <= aw_i.id;
      addr_q  <= aw_i.addr[WordOff +: $bits(word_addr_t)];
      cnt_q   <= aw_i.len;
    end else if (beat_fire) begin
      if (ar_fire) begin
        is_wr_q <= 1'b0;
      end
      id_q   <= beat_id;
      addr_q <= beat_addr + 1'b1;
      cnt_q  <= beat_cnt - 1'b1;
    end
  end

  // Beat register in front of the FIFO.
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      req_q.addr  <= beat_addr;
      req_q.wdata <= wr_fire ? w_i.data : '0;
      req_q.strb  <= wr_fire ? w_i.strb : '0;
      req_q.we    <= wr_fire;
      req_q.id    <= beat_id;
      req_q.last  <= beat_last;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;
  assign busy_o      = active_q || req_valid_q;

  // WLAST from the master must match the length given on AW.
  a_wlast_len: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_fire |-> (w_i.last == beat_last));

endmodule

`default_nettype wire

//--- rtl/axi_mem_pkg.sv
`default_nettype none

`include "axi_mem_settings.svh"

package axi_mem_pkg;

  // Basic AXI field types.
  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_ID_W-1:0]     id_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  // Beat count minus one, as on AxLEN.
  typedef logic [7:0]               len_t;

  // Word index, the same in every bank.
  typedef logic [$clog2(`MEM_WORDS)-1:0] word_addr_t;

  // Slice of a word held by one bank.
  typedef logic [`AXI_DATA_W/`MEM_NUM_BANKS-1:0]   bank_data_t;
  typedef logic [`AXI_DATA_W/`MEM_NUM_BANKS/8-1:0] bank_strb_t;

  // Free slot count of the response FIFO.
  typedef logic [$clog2(`RSP_FIFO_DEPTH+1)-1:0] rsp_cnt_t;

  // Write address channel.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  // Write data channel.
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response channel, always OKAY.
  typedef struct packed {
    id_t id;
  } b_chan_t;

  // Read address channel.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // Read data channel, always OKAY.
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_chan_t;

  // One unrolled beat towards the banks.
  typedef struct packed {
    word_addr_t addr;
    data_t      wdata;
    strb_t      strb;
    logic       we;
    id_t        id;
    logic       last;
  } mem_req_t;

  // One entry for the B or R channel.
  typedef struct packed {
    logic  is_write;
    id_t   id;
    data_t data;
    logic  last;
  } rsp_entry_t;

endpackage

`default_nettype wire

//--- rtl/axi_mem_settings.svh
`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// Byte address width of the AXI slave port.
`define AXI_ADDR_W 16
// AXI data width, one memory word per beat.
`define AXI_DATA_W 64
// Transaction ID width.
`define AXI_ID_W 4

// Banks split every word into equal slices.
`define MEM_NUM_BANKS 2
// Depth of each bank in words.
`define MEM_WORDS 256

// Beats buffered between unroller and response generator.
`define REQ_FIFO_DEPTH 4
// Responses buffered towards the B and R channels.
`define RSP_FIFO_DEPTH 4

`endif

//--- rtl/axi_to_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_to_mem_top import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // AXI slave port.
  input  aw_chan_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  w_chan_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output b_chan_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  output r_chan_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  output logic     busy_o
);

  // Unroller to request FIFO.
  mem_req_t unroll_req;
  logic     unroll_valid;
  logic     unroll_ready;
  // Request FIFO to response generator.
  mem_req_t gen_req;
  logic     gen_req_valid;
  logic     gen_req_ready;
  // Bank ports.
  logic       [`MEM_NUM_BANKS-1:0] bank_req;
  logic       [`MEM_NUM_BANKS-1:0] bank_we;
  word_addr_t [`MEM_NUM_BANKS-1:0] bank_addr;
  bank_data_t [`MEM_NUM_BANKS-1:0] bank_wdata;
  bank_strb_t [`MEM_NUM_BANKS-1:0] bank_strb;
  bank_data_t [`MEM_NUM_BANKS-1:0] bank_rdata;
  // Response generator to response FIFO.
  rsp_entry_t rsp_in;
  logic       rsp_in_valid;
  rsp_cnt_t   rsp_free;
  // Response FIFO head.
  rsp_entry_t rsp_head;
  logic       rsp_head_valid;
  logic       rsp_head_ready;

  axi_burst_unroll i_unroll (
    .clk_i       ( clk_i        ),
    .rst_i       ( rst_i        ),
    .aw_i        ( aw_i         ),
    .aw_valid_i  ( aw_valid_i   ),
    .aw_ready_o  ( aw_ready_o   ),
    .w_i         ( w_i          ),
    .w_valid_i   ( w_valid_i    ),
    .w_ready_o   ( w_ready_o    ),
    .ar_i        ( ar_i         ),
    .ar_valid_i  ( ar_valid_i   ),
    .ar_ready_o  ( ar_ready_o   ),
    .req_o       ( unroll_req   ),
    .req_valid_o ( unroll_valid ),
    .req_ready_i ( unroll_ready ),
    .busy_o      ( busy_o       )
  );

  stream_fifo #(
    .payload_t ( mem_req_t       ),
    .Depth     ( `REQ_FIFO_DEPTH )
  ) i_req_fifo (
    .clk_i   ( clk_i         ),
    .rst_i   ( rst_i         ),
    .data_i  ( unroll_req    ),
    .valid_i ( unroll_valid  ),
    .ready_o ( unroll_ready  ),
    .data_o  ( gen_req       ),
    .valid_o ( gen_req_valid ),
    .ready_i ( gen_req_ready ),
    .free_o  (               )
  );

  mem_resp_gen i_resp_gen (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .req_i        ( gen_req       ),
    .req_valid_i  ( gen_req_valid ),
    .req_ready_o  ( gen_req_ready ),
    .rsp_free_i   ( rsp_free      ),
    .bank_req_o   ( bank_req      ),
    .bank_we_o    ( bank_we       ),
    .bank_addr_o  ( bank_addr     ),
    .bank_wdata_o ( bank_wdata    ),
    .bank_strb_o  ( bank_strb     ),
    .bank_rdata_i ( bank_rdata    ),
    .rsp_o        ( rsp_in        ),
    .rsp_valid_o  ( rsp_in_valid  )
  );

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : gen_banks
    sram_bank i_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[b]   ),
      .we_i    ( bank_we[b]    ),
      .addr_i  ( bank_addr[b]  ),
      .wdata_i ( bank_wdata[b] ),
      .strb_i  ( bank_strb[b]  ),
      .rdata_o ( bank_rdata[b] )
    );
  end

  // Push side room is tracked through free_o, not ready_o.
  stream_fifo #(
    .payload_t ( rsp_entry_t     ),
    .Depth     ( `RSP_FIFO_DEPTH )
  ) i_rsp_fifo (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .data_i  ( rsp_in         ),
    .valid_i ( rsp_in_valid   ),
    .ready_o (                ),
    .data_o  ( rsp_head       ),
    .valid_o ( rsp_head_valid ),
    .ready_i ( rsp_head_ready ),
    .free_o  ( rsp_free       )
  );

  // Head entry goes to B or R by its kind.
  assign b_valid_o = rsp_head_valid && rsp_head.is_write;
  assign b_o.id    = rsp_head.id;
  assign r_valid_o = rsp_head_valid && !rsp_head.is_write;
  assign r_o.id    = rsp_head.id;
  assign r_o.data  = rsp_head.data;
  assign r_o.last  = rsp_head.last;

  // Pop on the ready of the channel that shows the head.
  assign rsp_head_ready = rsp_head.is_write ? b_ready_i : r_ready_i;

endmodule

`default_nettype wire

//--- rtl/mem_resp_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module mem_resp_gen import axi_mem_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Requests from the request FIFO.
  input  mem_req_t                            req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  // Room left in the response FIFO.
  input  rsp_cnt_t                            rsp_free_i,
  // Bank ports, one slice each.
  output logic       [`MEM_NUM_BANKS-1:0]     bank_req_o,
  output logic       [`MEM_NUM_BANKS-1:0]     bank_we_o,
  output word_addr_t [`MEM_NUM_BANKS-1:0]     bank_addr_o,
  output bank_data_t [`MEM_NUM_BANKS-1:0]     bank_wdata_o,
  output bank_strb_t [`MEM_NUM_BANKS-1:0]     bank_strb_o,
  input  bank_data_t [`MEM_NUM_BANKS-1:0]     bank_rdata_i,
  // Entries into the response FIFO.
  output rsp_entry_t                          rsp_o,
  output logic                                rsp_valid_o
);

  localparam int unsigned BankW = $bits(bank_data_t);
  localparam int unsigned BankS = $bits(bank_strb_t);

  // Beat metadata held while the banks read.
  typedef struct packed {
    logic we;
    id_t  id;
    logic last;
  } meta_t;

  meta_t    meta_q;
  logic     meta_valid_q;
  logic     issue;
  rsp_cnt_t in_flight;

  // Only reads and last write beats need a response slot.
  assign rsp_valid_o = meta_valid_q && (!meta_q.we || meta_q.last);
  // The beat now in the banks will take one slot next cycle.
  assign in_flight   = rsp_cnt_t'(rsp_valid_o);
  assign req_ready_o = (rsp_free_i > in_flight);
  assign issue       = req_valid_i && req_ready_o;

  // Banks always grant, so issue goes out in the pop cycle.
  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      bank_req_o[b]   = issue;
      bank_we_o[b]    = issue && req_i.we;
      bank_addr_o[b]  = req_i.addr;
      bank_wdata_o[b] = req_i.wdata[b*BankW +: BankW];
      bank_strb_o[b]  = req_i.strb[b*BankS +: BankS];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      meta_valid_q <= 1'b0;
    end else begin
      meta_valid_q <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      meta_q.we   <= req_i.we;
      meta_q.id   <= req_i.id;
      meta_q.last <= req_i.last;
    end
  end

  // Bank zero carries the low half of the word.
  always_comb begin
    rsp_o.is_write = meta_q.we;
    rsp_o.id       = meta_q.id;
    rsp_o.last     = meta_q.last;
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      rsp_o.data[b*BankW +: BankW] = bank_rdata_i[b];
    end
  end

  // The in-flight count must keep the response FIFO from overflowing.
  a_rsp_room: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o |-> (rsp_free_i != '0));

endmodule

`default_nettype wire

//--- rtl/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module sram_bank import axi_mem_pkg::*; (
  input  logic       clk_i,
  input  logic       req_i,
  input  logic       we_i,
  input  word_addr_t addr_i,
  input  bank_data_t wdata_i,
  input  bank_strb_t strb_i,
  output bank_data_t rdata_o
);

  bank_data_t mem_q [`MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      // Byte lanes without strobe keep their contents.
      if (we_i) begin
        for (int i = 0; i < $bits(bank_strb_t); i++) begin
          if (strb_i[i]) begin
            mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end
      // Read data follows one cycle after any request.
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- rtl/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Push side.
  input  payload_t                     data_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  // Pop side.
  output payload_t                     data_o,
  output logic                         valid_o,
  input  logic                         ready_i,
  output logic [$clog2(Depth+1)-1:0]   free_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            full;
  logic            empty;
  logic            push;
  logic            pop;

  // Pointers wrap at Depth, which need not be a power of two.
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (cnt_q == CntW'(Depth));
  assign empty   = (cnt_q == '0);
  assign ready_o = !full;
  assign valid_o = !empty;
  assign data_o  = mem_q[rd_ptr_q];
  assign free_o  = CntW'(Depth) - cnt_q;
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Count moves only when one side is idle.
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // An entry offered to a full buffer waits unchanged for room.
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_i && !ready_o) |=> (valid_i && $stable(data_i)));
  // Equal pointers only at the two ends of the count.
  a_ptr_cnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (wr_ptr_q == rd_ptr_q) |-> (full || empty));

endmodule

`default_nettype wire
